/* Bender.yml */
package:
  name: heater_panel

sources:
  - files:
      - verilog/heater_pkg.sv
      - verilog/display_pkg.sv
      - verilog/heater_command_regs.sv
      - verilog/pwm_channels.sv
      - verilog/seven_seg_bank.sv
      - verilog/status_painter.sv
      - verilog/heater_panel_top.sv
  - target: test
    files:
      - tb/heater_panel_tb.sv

/* sources.f */
verilog/heater_pkg.sv
verilog/display_pkg.sv
verilog/heater_command_regs.sv
verilog/pwm_channels.sv
verilog/seven_seg_bank.sv
verilog/status_painter.sv
verilog/heater_panel_top.sv
tb/heater_panel_tb.sv

/* tb/heater_panel_patterns.txt */
// Each record is 11 hex digits: kind(1) f1(3) f2(3) f3(4), kind 0 ends the list
// kind 1 command: op channel value | kind 2 PWM: channel - high clocks | kind 3 pixel: x y colour
// Duty 2A7 on channel 0, 3FF on channel 1
100000002A7
100000103FF
20000000A9C
20010000FFC
// Duty 0 gives a constant low output
10000000000
20000000000
// Channel 0 on, channel 1 off, progress 20
10010000001
10010010000
10020000014
// Glyph rectangles
3019032FFFF
3055028FFFF
311003CFFFF
// Status squares
303706E00FE
302305A00FE
30FF06EFF00
3113082FF00
// Progress bar, offsets 0, 1, 20, 21 and 80
30780C8FFFF
30790D20000
308C0DC0013
308D0CD0000
30C80C80000
// Background
30000000000
313F0EF0000
30640640000
30770C80000

/* tb/heater_panel_tb.sv */
/*
 Testbench for the heater panel. Commands, PWM checks and pixel probes come
 from tb/heater_panel_patterns.txt, which is read relative to the project root.
 Inputs change on the falling edge, the pixel stream is checked on the rising edge.
*/
`timescale 1ns/100ps
`default_nettype none

module heater_panel_tb;
	import heater_pkg::*;
	import display_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int PWM_PERIOD   = PWM_STEPS * PWM_PRESCALE;  // Clocks per ramp period
	localparam int FRAME_PIXELS = FRAME_W * FRAME_H;
	localparam int MAX_RECS     = 64;

	// Active-low hex digits with bit 6 as segment g
	localparam seg_t HEX_SEG [16] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
		7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
		7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
		7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
	};

	logic        CLOCK_50 = 1'b0;
	logic        rst_n_i;
	heater_cmd_t cmd_i;
	logic        cmd_valid_i;
	logic        cmd_ready_o;
	logic [1:0]  pwm_o;
	seg_t [5:0]  seg_o;
	pixel_wr_t   pix_o;
	logic        pix_valid_o;
	logic        pix_ready_i;

	// Record holds kind in [43:40], f1 in [39:28], f2 in [27:16] and f3 in [15:0]
	logic [43:0] recs [MAX_RECS];
	pixel_wr_t   probes [MAX_RECS];
	bit          probe_seen [MAX_RECS];
	int          n_probes;
	int          probes_seen;
	duty_t       duty_model [2];   // Expected register contents
	int          value_errors;
	int          other_errors;
	int          limit_cycles = 0;
	int          seed = 30;

	bit          probing;
	bit          skip_first;
	bit          have_prev;
	bit          stalled;
	int          arm_accepts;
	pixel_wr_t   prev_pix;
	pixel_wr_t   held_pix;

	heater_panel_top uut
	(
		.CLOCK_50    (CLOCK_50),
		.rst_n_i     (rst_n_i),
		.cmd_i       (cmd_i),
		.cmd_valid_i (cmd_valid_i),
		.cmd_ready_o (cmd_ready_o),
		.pwm_o       (pwm_o),
		.seg_o       (seg_o),
		.pix_o       (pix_o),
		.pix_valid_o (pix_valid_o),
		.pix_ready_i (pix_ready_i)
	);

	always #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;

	always @(negedge CLOCK_50)
	begin
		int r;
		r = $random(seed);
		pix_ready_i = (r[1:0] != 2'b00); // Roughly 3 in 4 cycles ready
	end

	task automatic check_ready(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("ERROR at %0t ns: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_pwm(input string name, input int got, input int exp);
		if (got != exp)
		begin
			value_errors++;
			$display("ERROR at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_seg(input string name, input seg_t got, input seg_t exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("ERROR at %0t ns: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_pixel(input string name, input pixel_wr_t got, input pixel_wr_t exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("ERROR at %0t ns: %s got (%0d,%0d) %h expected (%0d,%0d) %h", $time, name,
				got.x, got.y, got.colour, exp.x, exp.y, exp.colour);
		end
	endtask

	// Raster order with x first and the frame end back to the origin
	function automatic pixel_wr_t next_position(input pixel_wr_t p);
		pixel_wr_t n;
		n = p;
		if (p.x == coord_x_t'(FRAME_W - 1))
		begin
			n.x = '0;
			n.y = (p.y == coord_y_t'(FRAME_H - 1)) ? '0 : p.y + 1'b1;
		end
		else
			n.x = p.x + 1'b1;
		return n;
	endfunction

	// Low nibble, middle nibble and bits 9:8 on the top digit
	task automatic check_digits();
		for (int ch = 0; ch < 2; ch++)
		begin
			check_seg($sformatf("seg_o[%0d]", 3 * ch), seg_o[3 * ch],
				HEX_SEG[duty_model[ch][3:0]]);
			check_seg($sformatf("seg_o[%0d]", 3 * ch + 1), seg_o[3 * ch + 1],
				HEX_SEG[duty_model[ch][7:4]]);
			check_seg($sformatf("seg_o[%0d]", 3 * ch + 2), seg_o[3 * ch + 2],
				HEX_SEG[{2'b00, duty_model[ch][9:8]}]);
		end
	endtask

	task automatic send_cmd(input logic [43:0] rec);
		heater_cmd_t c;
		int          waited;
		c.op      = heater_op_e'(rec[29:28]);
		c.channel = rec[16];
		c.value   = rec[9:0];
		waited    = 0;
		cmd_i       = c;
		cmd_valid_i = 1'b1;
		while (cmd_ready_o !== 1'b1 && waited < 16)
		begin
			@(negedge CLOCK_50);
			waited++;
		end
		if (cmd_ready_o !== 1'b1)
		begin
			other_errors++;
			$display("Command was never accepted, cmd_ready_o stayed low");
			cmd_valid_i = 1'b0;
		end
		else
		begin
			check_digits();          // Still the old value before the edge
			@(negedge CLOCK_50);     // Accepted on the rising edge in between
			cmd_valid_i = 1'b0;
			if (c.op == CMD_SET_DUTY)
				duty_model[c.channel] = c.value;
			check_digits();
		end
	endtask

	// Skip one period so the new duty is loaded, then count one period from a rise
	task automatic measure_pwm(input int ch, output int high_cnt);
		int waited;
		high_cnt = 0;
		waited   = 0;
		repeat (PWM_PERIOD) @(negedge CLOCK_50);
		while (pwm_o[ch] === 1'b1 && waited < 2 * PWM_PERIOD)
		begin
			@(negedge CLOCK_50);
			waited++;
		end
		while (pwm_o[ch] !== 1'b1 && waited < 2 * PWM_PERIOD)
		begin
			@(negedge CLOCK_50);
			waited++;
		end
		repeat (PWM_PERIOD)
		begin
			if (pwm_o[ch] === 1'b1)
				high_cnt++;
			@(negedge CLOCK_50);
		end
	endtask

	// Pixel stream monitor checks hold while stalled, raster order and probe colours
	always @(posedge CLOCK_50)
	begin
		pixel_wr_t expect_pix;
		if (rst_n_i)
		begin
			if (stalled)
			begin
				if (pix_valid_o !== 1'b1)
				begin
					other_errors++;
					$display("Pixel valid dropped at %0t ns before the pixel was accepted", $time);
				end
				else
					check_pixel("pix_o stalled", pix_o, held_pix);
			end
			if (pix_valid_o === 1'b1 && pix_ready_i === 1'b1)
			begin
				expect_pix        = have_prev ? next_position(prev_pix) : '0;
				expect_pix.colour = pix_o.colour; // Position only here
				check_pixel("pix_o position", pix_o, expect_pix);
				prev_pix  = pix_o;
				have_prev = 1'b1;
				stalled   = 1'b0;
				if (probing)
				begin
					if (skip_first)
						skip_first = 1'b0; // May have been formed before the commands
					else
					begin
						for (int i = 0; i < n_probes; i++)
						begin
							if (!probe_seen[i] && pix_o.x == probes[i].x && pix_o.y == probes[i].y)
							begin
								check_pixel("pix_o colour", pix_o, probes[i]);
								probe_seen[i] = 1'b1;
								probes_seen++;
							end
						end
					end
					arm_accepts++;
				end
			end
			else if (pix_valid_o === 1'b1)
			begin
				stalled  = 1'b1;
				held_pix = pix_o;
			end
			else
				stalled = 1'b0;
		end
	end

	initial
	begin
		int n_pwm;
		int n_cmds;
		int n_recs;
		int cnt;
		$timeformat(-9, 0, "", 0);
		rst_n_i     = 1'b0;
		cmd_i       = '0;
		cmd_valid_i = 1'b0;
		pix_ready_i = 1'b0;
		value_errors = 0;
		other_errors = 0;
		duty_model[0] = '0;
		duty_model[1] = '0;
		n_probes = 0;
		probes_seen = 0;
		n_pwm  = 0;
		n_cmds = 0;
		n_recs = 0;
		for (int i = 0; i < MAX_RECS; i++)
		begin
			recs[i]       = '0;
			probe_seen[i] = 1'b0;
		end
		$readmemh("tb/heater_panel_patterns.txt", recs);
		for (int i = 0; i < MAX_RECS && recs[i][43:40] != 4'h0; i++)
		begin
			n_recs++;
			if (recs[i][43:40] == 4'h1)
				n_cmds++;
			else if (recs[i][43:40] == 4'h2)
				n_pwm++;
			else if (recs[i][43:40] == 4'h3)
			begin
				probes[n_probes].x      = recs[i][36:28];
				probes[n_probes].y      = recs[i][23:16];
				probes[n_probes].colour = recs[i][15:0];
				n_probes++;
			end
		end
		if (n_recs == 0)
		begin
			other_errors++;
			$display("Pattern file held no records");
		end
		// Two frames at 4 cycles per pixel, 4 periods per PWM check, plus margin
		limit_cycles = 2 * FRAME_PIXELS * 4 + n_pwm * 4 * PWM_PERIOD + n_cmds * 32 + 1000;

		repeat (2) @(negedge CLOCK_50);
		check_ready("cmd_ready_o", cmd_ready_o, 1'b0);
		check_ready("pix_valid_o", pix_valid_o, 1'b0);
		check_ready("pwm_o[0]", pwm_o[0], 1'b0);
		check_ready("pwm_o[1]", pwm_o[1], 1'b0);
		rst_n_i = 1'b1;
		@(negedge CLOCK_50);
		check_ready("cmd_ready_o", cmd_ready_o, 1'b1);
		check_digits();

		for (int i = 0; i < n_recs; i++)
		begin
			if (recs[i][43:40] == 4'h1)
				send_cmd(recs[i]);
			else if (recs[i][43:40] == 4'h2)
			begin
				measure_pwm(recs[i][28], cnt);
				check_pwm($sformatf("pwm_o[%0d] high clocks", recs[i][28]), cnt, recs[i][15:0]);
			end
			else if (recs[i][43:40] != 4'h3)
			begin
				other_errors++;
				$display("Pattern record %0d has an unknown kind", i);
			end
		end

		if (n_probes > 0)
		begin
			arm_accepts = 0;
			skip_first  = 1'b1;
			probing     = 1'b1;
			while (probes_seen < n_probes && arm_accepts <= FRAME_PIXELS)
				@(negedge CLOCK_50);
			probing = 1'b0;
			for (int i = 0; i < n_probes; i++)
			begin
				if (!probe_seen[i])
				begin
					other_errors++;
					$display("Pixel (%0d,%0d) was not accepted within one frame",
						probes[i].x, probes[i].y);
				end
			end
		end

		$display("Done: %0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge CLOCK_50);
		$display("Timeout: run did not finish within %0d clock cycles", limit_cycles);
		$display("Done: %0d value errors, %0d other errors", value_errors, other_errors);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/display_pkg.sv */
/*
 Frame geometry, colours and region table of the status frame.
 All rectangle bounds are inclusive on both ends.
 Segment patterns are active low, bit 6 is segment g.
*/
`default_nettype none

package display_pkg;

	localparam int FRAME_W = 320;
	localparam int FRAME_H = 240;

	typedef logic [8:0]  coord_x_t;
	typedef logic [7:0]  coord_y_t;
	typedef logic [15:0] colour_t;

	localparam colour_t COLOUR_WHITE = 16'hFFFF;
	localparam colour_t COLOUR_GREEN = 16'h00FE;
	localparam colour_t COLOUR_RED   = 16'hFF00;
	localparam colour_t COLOUR_BLACK = 16'h0000;

	typedef struct packed
	{
		coord_x_t x;
		coord_y_t y;
		colour_t  colour;
	} pixel_wr_t;

	typedef enum logic
	{
		PAINT_EMIT    = 1'b0,
		PAINT_ADVANCE = 1'b1
	} paint_state_e;

	typedef struct packed
	{
		coord_x_t x0;
		coord_x_t x1;
		coord_y_t y0;
		coord_y_t y1;
	} glyph_rect_t;

	// "H1" label on the left, "H2" on the right
	localparam int GLYPH_COUNT = 12;
	localparam glyph_rect_t GLYPH_RECTS [GLYPH_COUNT] = '{
		'{9'd20,  9'd30,  8'd30, 8'd70},   // H left stroke
		'{9'd30,  9'd50,  8'd45, 8'd55},   // H bar
		'{9'd50,  9'd60,  8'd30, 8'd70},   // H right stroke
		'{9'd80,  9'd90,  8'd30, 8'd70},   // Digit 1
		'{9'd210, 9'd220, 8'd30, 8'd70},
		'{9'd220, 9'd240, 8'd45, 8'd55},
		'{9'd240, 9'd250, 8'd30, 8'd70},
		'{9'd270, 9'd300, 8'd30, 8'd35},   // Digit 2 top
		'{9'd270, 9'd300, 8'd47, 8'd53},   // Middle
		'{9'd270, 9'd300, 8'd65, 8'd70},   // Bottom
		'{9'd295, 9'd300, 8'd35, 8'd47},
		'{9'd270, 9'd275, 8'd53, 8'd65}
	};

	// Heater status squares, index is the channel
	localparam glyph_rect_t STATUS_SQ [2] = '{
		'{9'd35,  9'd75,  8'd90, 8'd130},
		'{9'd235, 9'd275, 8'd90, 8'd130}
	};

	localparam coord_x_t BAR_X0 = 9'd120;
	localparam coord_x_t BAR_X1 = 9'd200;
	localparam coord_y_t BAR_Y0 = 8'd200;
	localparam coord_y_t BAR_Y1 = 8'd220;

	typedef logic [6:0] seg_t;

endpackage

`default_nettype wire

/* verilog/heater_command_regs.sv */
/*
 Command register file for two heaters and the progress value.
 Every command is absorbed in one cycle, so ready only drops in reset.
 Register contents change on the edge after acceptance.
*/
`timescale 1ns/100ps
`default_nettype none

module heater_command_regs
(
	input  wire                          CLOCK_50,
	input  wire                          rst_n_i,
	input  heater_pkg::heater_cmd_t      cmd_i,
	input  wire                          cmd_valid_i,
	output logic                         cmd_ready_o,
	output heater_pkg::duty_t [1:0]      duty_o,
	output logic [1:0]                   heater_on_o,
	output logic [7:0]                   progress_o
);
	import heater_pkg::*;

	logic accept;

	assign accept = cmd_valid_i & cmd_ready_o;

	// Ready rises on the first edge out of reset
	always_ff @(posedge CLOCK_50 or negedge rst_n_i)
	begin
		if (!rst_n_i)
			cmd_ready_o <= 1'b0;
		else
			cmd_ready_o <= 1'b1;
	end

	always_ff @(posedge CLOCK_50 or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			duty_o      <= '0;
			heater_on_o <= 2'b00;
			progress_o  <= 8'd0;
		end
		else if (accept)
		begin
			case (cmd_i.op)
				CMD_SET_DUTY:     duty_o[cmd_i.channel] <= cmd_i.value;
				CMD_SET_STATUS:   heater_on_o[cmd_i.channel] <= cmd_i.value[0];
				CMD_SET_PROGRESS: progress_o <= cmd_i.value[7:0]; // Shared by both heaters
				default:          ; // Unused opcode is dropped
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/heater_panel_top.sv */
/*
 Heater panel top: command registers, PWM, hex display and frame painter.
 The pixel stream is meant for an external frame buffer writer.
*/
`timescale 1ns/100ps
`default_nettype none

module heater_panel_top
(
	input  wire                        CLOCK_50,
	input  wire                        rst_n_i,
	input  heater_pkg::heater_cmd_t    cmd_i,
	input  wire                        cmd_valid_i,
	output logic                       cmd_ready_o,
	output logic [1:0]                 pwm_o,
	output display_pkg::seg_t [5:0]    seg_o,
	output display_pkg::pixel_wr_t     pix_o,
	output logic                       pix_valid_o,
	input  wire                        pix_ready_i
);
	import heater_pkg::*;

	duty_t [1:0] duty;      // Live duty registers
	logic  [1:0] heater_on;
	logic  [7:0] progress;

	heater_command_regs u_regs
	(
		.CLOCK_50    (CLOCK_50),
		.rst_n_i     (rst_n_i),
		.cmd_i       (cmd_i),
		.cmd_valid_i (cmd_valid_i),
		.cmd_ready_o (cmd_ready_o),
		.duty_o      (duty),
		.heater_on_o (heater_on),
		.progress_o  (progress)
	);

	pwm_channels u_pwm
	(
		.CLOCK_50 (CLOCK_50),
		.rst_n_i  (rst_n_i),
		.duty_i   (duty),
		.pwm_o    (pwm_o)
	);

	seven_seg_bank u_seg
	(
		.duty_i (duty),
		.seg_o  (seg_o)
	);

	status_painter u_painter
	(
		.CLOCK_50    (CLOCK_50),
		.rst_n_i     (rst_n_i),
		.heater_on_i (heater_on),
		.progress_i  (progress),
		.pix_o       (pix_o),
		.pix_valid_o (pix_valid_o),
		.pix_ready_i (pix_ready_i)
	);

endmodule

`default_nettype wire

/* verilog/heater_pkg.sv */
/*
 Command and PWM definitions for the heater panel.
 The opcode is 2 bits and the command value is 10 bits wide.
 PWM period is PWM_STEPS ramp steps of PWM_PRESCALE clocks each.
*/
`default_nettype none

package heater_pkg;

	typedef enum logic [1:0]
	{
		CMD_SET_DUTY     = 2'd0,
		CMD_SET_STATUS   = 2'd1,
		CMD_SET_PROGRESS = 2'd2
	} heater_op_e;

	typedef logic [9:0] duty_t;

	// For SET_STATUS only value[0] matters; SET_PROGRESS uses value[7:0]
	typedef struct packed
	{
		heater_op_e  op;
		logic        channel; // Heater select, 0 or 1
		logic [9:0]  value;
	} heater_cmd_t;

	localparam int PWM_PRESCALE = 4;    // Clocks per ramp step
	localparam int PWM_STEPS    = 1024; // Ramp steps per period

	// Derived widths and limits
	localparam int    PRESCALE_W = $clog2(PWM_PRESCALE);
	localparam duty_t RAMP_LAST  = duty_t'(PWM_STEPS - 1);

endpackage

`default_nettype wire

/* verilog/pwm_channels.sv */
/*
 Two PWM outputs sharing one prescaler and one 10-bit ramp.
 A duty value is taken at the ramp wrap, so a change shows from the next period.
 High time per period is duty * PWM_PRESCALE clocks.
*/
`timescale 1ns/100ps
`default_nettype none

module pwm_channels
(
	input  wire                     CLOCK_50,
	input  wire                     rst_n_i,
	input  heater_pkg::duty_t [1:0] duty_i,
	output logic [1:0]              pwm_o
);
	import heater_pkg::*;

	logic [PRESCALE_W-1:0] pre_cnt;
	logic                  tick;
	logic                  wrap;
	duty_t                 ramp;
	duty_t [1:0]           shadow;  // Duty in force for this period

	assign tick = (pre_cnt == PRESCALE_W'(PWM_PRESCALE - 1));
	assign wrap = tick && (ramp == RAMP_LAST);

	always_ff @(posedge CLOCK_50 or negedge rst_n_i)
	begin
		if (!rst_n_i)
			pre_cnt <= '0;
		else if (tick)
			pre_cnt <= '0;
		else
			pre_cnt <= pre_cnt + 1'b1;
	end

	// Ramp steps once per prescaler tick
	always_ff @(posedge CLOCK_50 or negedge rst_n_i)
	begin
		if (!rst_n_i)
			ramp <= '0;
		else if (wrap)
			ramp <= '0;
		else if (tick)
			ramp <= ramp + 1'b1;
	end

	// Load both channels on the same edge the ramp returns to zero
	always_ff @(posedge CLOCK_50 or negedge rst_n_i)
	begin
		if (!rst_n_i)
			shadow <= '0;
		else if (wrap)
			shadow <= duty_i;
	end

	always_comb
	begin
		for (int ch = 0; ch < 2; ch++)
			pwm_o[ch] = (ramp < shadow[ch]);
	end

endmodule

`default_nettype wire

/* verilog/seven_seg_bank.sv */
/*
 Shows both duty values as hex on six active-low seven-segment digits.
 Digits 0..2 are channel 0, digits 3..5 channel 1; top digit holds bits 9:8.
 Purely combinational.
*/
`timescale 1ns/100ps
`default_nettype none

module seven_seg_bank
(
	input  heater_pkg::duty_t [1:0]   duty_i,
	output display_pkg::seg_t [5:0]   seg_o
);
	import display_pkg::*;

	function automatic seg_t hex_seg(input logic [3:0] nib);
		seg_t s;
		case (nib)
			4'h0: s = 7'b1000000;
			4'h1: s = 7'b1111001;
			4'h2: s = 7'b0100100;
			4'h3: s = 7'b0110000;
			4'h4: s = 7'b0011001;
			4'h5: s = 7'b0010010;
			4'h6: s = 7'b0000010;
			4'h7: s = 7'b1111000;
			4'h8: s = 7'b0000000;
			4'h9: s = 7'b0010000;
			4'hA: s = 7'b0001000;
			4'hB: s = 7'b0000011;
			4'hC: s = 7'b1000110;
			4'hD: s = 7'b0100001;
			4'hE: s = 7'b0000110;
			default: s = 7'b0001110; // F
		endcase
		return s;
	endfunction

	always_comb
	begin
		for (int ch = 0; ch < 2; ch++)
		begin
			seg_o[3*ch]     = hex_seg(duty_i[ch][3:0]);
			seg_o[3*ch + 1] = hex_seg(duty_i[ch][7:4]);
			seg_o[3*ch + 2] = hex_seg({2'b00, duty_i[ch][9:8]}); // Only 0..3
		end
	end

endmodule

`default_nettype wire

/* verilog/status_painter.sv */
/*
 Paints the 320x240 status frame as a stream of pixel writes, raster order.
 One pixel per acceptance, then one idle cycle while the position advances.
 Status and progress are taken at the moment a pixel is formed.
 A stalled pixel keeps its colour even if status changes meanwhile.
*/
`timescale 1ns/100ps
`default_nettype none

module status_painter
(
	input  wire                     CLOCK_50,
	input  wire                     rst_n_i,
	input  wire [1:0]               heater_on_i,
	input  wire [7:0]               progress_i,
	output display_pkg::pixel_wr_t  pix_o,
	output logic                    pix_valid_o,
	input  wire                     pix_ready_i
);
	import display_pkg::*;

	paint_state_e state_q;
	coord_x_t     x_q;      // Position of the next pixel to form
	coord_y_t     y_q;
	coord_x_t     x_next;
	coord_y_t     y_next;
	pixel_wr_t    pix_q;

	function automatic logic in_rect(input glyph_rect_t r, input coord_x_t x,
		input coord_y_t y);
		return (x >= r.x0) && (x <= r.x1) && (y >= r.y0) && (y <= r.y1);
	endfunction

	// Region priority: glyphs, status squares, progress bar, background
	function automatic colour_t colour_at(input coord_x_t x, input coord_y_t y,
		input logic [1:0] on, input logic [7:0] progress);
		coord_x_t offset;
		logic     hit_glyph;
		colour_t  c;
		offset    = x - BAR_X0;
		hit_glyph = 1'b0;
		for (int i = 0; i < GLYPH_COUNT; i++)
			hit_glyph |= in_rect(GLYPH_RECTS[i], x, y);
		if (hit_glyph)
			c = COLOUR_WHITE;
		else if (in_rect(STATUS_SQ[0], x, y))
			c = on[0] ? COLOUR_GREEN : COLOUR_RED;
		else if (in_rect(STATUS_SQ[1], x, y))
			c = on[1] ? COLOUR_GREEN : COLOUR_RED;
		else if (x >= BAR_X0 && x <= BAR_X1 && y >= BAR_Y0 && y <= BAR_Y1)
		begin
			if (offset <= coord_x_t'(progress))
				c = COLOUR_WHITE + colour_t'(offset); // Gradient wraps past FFFF
			else
				c = COLOUR_BLACK;
		end
		else
			c = COLOUR_BLACK;
		return c;
	endfunction

	// Raster successor, x first, full frame wraps to the origin
	always_comb
	begin
		x_next = x_q + 1'b1;
		y_next = y_q;
		if (x_q == coord_x_t'(FRAME_W - 1))
		begin
			x_next = '0;
			if (y_q == coord_y_t'(FRAME_H - 1))
				y_next = '0;
			else
				y_next = y_q + 1'b1;
		end
	end

	always_ff @(posedge CLOCK_50 or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state_q <= PAINT_ADVANCE; // First pass forms (0,0)
			x_q     <= '0;
			y_q     <= '0;
		end
		else
		begin
			case (state_q)
				PAINT_ADVANCE:
				begin
					x_q     <= x_next;
					y_q     <= y_next;
					state_q <= PAINT_EMIT;
				end
				PAINT_EMIT:
				begin
					if (pix_ready_i)
						state_q <= PAINT_ADVANCE;
				end
				default: state_q <= PAINT_ADVANCE;
			endcase
		end
	end

	// Pixel is formed on entry to PAINT_EMIT and held until accepted
	always_ff @(posedge CLOCK_50)
	begin
		if (state_q == PAINT_ADVANCE)
		begin
			pix_q.x      <= x_q;
			pix_q.y      <= y_q;
			pix_q.colour <= colour_at(x_q, y_q, heater_on_i, progress_i);
		end
	end

	assign pix_o       = pix_q;
	assign pix_valid_o = (state_q == PAINT_EMIT);

endmodule

`default_nettype wire
